// ==== hdl/exec_defines.svh ====
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// datapath width of the execute stage
`define EXEC_XLEN 64

// shift amount for full-width shifts
`define EXEC_SHAMT_W 6

// shift amount for 32-bit word shifts
`define EXEC_SHAMT_W_WORD 5

`endif

// ==== hdl/exec_pkg.sv ====
`default_nettype none

`include "exec_defines.svh"

package exec_pkg;

	// class handed over by the main decoder
	typedef enum logic [1:0] {
		CLASS_MEM    = 2'd0, // load/store address add
		CLASS_BRANCH = 2'd1, // compare by subtraction
		CLASS_REG    = 2'd2, // register-register
		CLASS_IMM    = 2'd3  // register-immediate
	} alu_class_e;

	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_AND  = 4'd2,
		OP_OR   = 4'd3,
		OP_XOR  = 4'd4,
		OP_SLT  = 4'd5,
		OP_SLTU = 4'd6,
		OP_SLL  = 4'd7,
		OP_SRL  = 4'd8,
		OP_SRA  = 4'd9
	} alu_op_e;

	typedef struct packed {
		alu_op_e op;
		logic    word; // 32-bit form, result sign-extended
	} alu_ctrl_t;

	typedef struct packed {
		alu_class_e            cls;
		logic [2:0]            funct3;
		logic [6:0]            funct7;
		logic                  word;
		logic [`EXEC_XLEN-1:0] op_a;
		logic [`EXEC_XLEN-1:0] op_b;
	} ex_req_t;

	typedef struct packed {
		logic [`EXEC_XLEN-1:0] result;
		logic                  zero;
		logic                  illegal;
	} ex_resp_t;

endpackage

`default_nettype wire

// ==== hdl/alu_ctrl_decode.sv ====
`default_nettype none

`include "exec_defines.svh"

module alu_ctrl_decode (
	input  exec_pkg::alu_class_e cls,
	input  logic [2:0]           funct3,
	input  logic [6:0]           funct7,
	input  logic                 word,
	output exec_pkg::alu_ctrl_t  ctrl,
	output logic                 illegal
);

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;
	localparam logic [6:0] F7_SHIFT_RSVD = 7'b1011110; // bit 5 picks sra, bit 0 is shamt[5]

	exec_pkg::alu_op_e op;
	logic              use_funct;
	logic              shift;

	assign use_funct = (cls == exec_pkg::CLASS_REG) || (cls == exec_pkg::CLASS_IMM);
	assign shift     = (funct3 == 3'b001) || (funct3 == 3'b101);

	always_comb begin
		case (cls)
			exec_pkg::CLASS_MEM:    op = exec_pkg::OP_ADD;
			exec_pkg::CLASS_BRANCH: op = exec_pkg::OP_SUB;
			default: begin
				case (funct3)
					3'b000: begin
						if (cls == exec_pkg::CLASS_REG && funct7 == F7_ALT) begin
							op = exec_pkg::OP_SUB;
						end else begin
							op = exec_pkg::OP_ADD; // addi has no sub form
						end
					end
					3'b001:  op = exec_pkg::OP_SLL;
					3'b010:  op = exec_pkg::OP_SLT;
					3'b011:  op = exec_pkg::OP_SLTU;
					3'b100:  op = exec_pkg::OP_XOR;
					3'b101:  op = funct7[5] ? exec_pkg::OP_SRA : exec_pkg::OP_SRL;
					3'b110:  op = exec_pkg::OP_OR;
					default: op = exec_pkg::OP_AND;
				endcase
			end
		endcase
	end

	always_comb begin
		illegal = 1'b0;
		if (cls == exec_pkg::CLASS_REG) begin
			if (funct7 != F7_BASE && funct7 != F7_ALT) begin
				illegal = 1'b1;
			end
			if (funct7 == F7_ALT && funct3 != 3'b000 && funct3 != 3'b101) begin
				illegal = 1'b1; // only sub and sra use the alternate funct7
			end
		end
		if (cls == exec_pkg::CLASS_IMM && shift && (funct7 & F7_SHIFT_RSVD) != F7_BASE) begin
			illegal = 1'b1;
		end
		if (use_funct && word && funct3 inside {3'b010, 3'b011, 3'b100, 3'b110, 3'b111}) begin
			illegal = 1'b1; // no word form of compares or logic ops
		end
	end

	// illegal falls back to a plain 64-bit add
	assign ctrl = '{op: (illegal ? exec_pkg::OP_ADD : op), word: (use_funct & word & ~illegal)};

endmodule

`default_nettype wire

// ==== hdl/barrel_shifter.sv ====
`default_nettype none

`include "exec_defines.svh"

module barrel_shifter (
	input  logic [`EXEC_XLEN-1:0]    din,
	input  logic [`EXEC_SHAMT_W-1:0] shamt,
	input  logic                     left,
	input  logic                     arith,
	output logic [`EXEC_XLEN-1:0]    dout
);

	logic                  fill;
	logic [`EXEC_XLEN-1:0] data;
	logic [`EXEC_XLEN:0]   ext; // fill bit on top of the data

	assign fill = arith & ~left & din[`EXEC_XLEN-1];

	// left shifts run through the same right-shift stages on bit-reversed data
	always_comb begin
		for (int i = 0; i < `EXEC_XLEN; i++) begin
			data[i] = left ? din[`EXEC_XLEN-1-i] : din[i];
		end
		for (int k = 0; k < `EXEC_SHAMT_W; k++) begin
			ext = {fill, data};
			if (shamt[k]) begin
				ext = $signed(ext) >>> (1 << k); // stage k moves by 2**k
			end
			data = ext[`EXEC_XLEN-1:0];
		end
		for (int i = 0; i < `EXEC_XLEN; i++) begin
			dout[i] = left ? data[`EXEC_XLEN-1-i] : data[i];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`default_nettype none

`include "exec_defines.svh"

module alu (
	input  exec_pkg::alu_ctrl_t   ctrl,
	input  logic [`EXEC_XLEN-1:0] op_a,
	input  logic [`EXEC_XLEN-1:0] op_b,
	output logic [`EXEC_XLEN-1:0] result,
	output logic                  zero
);

	localparam int WLEN = `EXEC_XLEN / 2;

	// adder, shared by add, sub and both compares
	logic                  sub;
	logic [`EXEC_XLEN-1:0] b_in;
	logic [`EXEC_XLEN-1:0] sum;
	logic                  carry;
	logic                  overflow;
	logic                  lt_s;
	logic                  lt_u;

	// shifter operands
	logic                     sh_left;
	logic                     sh_arith;
	logic [`EXEC_XLEN-1:0]    sh_in;
	logic [`EXEC_SHAMT_W-1:0] sh_amt;
	logic [`EXEC_XLEN-1:0]    sh_out;

	logic [`EXEC_XLEN-1:0] raw;

	assign sub  = ctrl.op inside {exec_pkg::OP_SUB, exec_pkg::OP_SLT, exec_pkg::OP_SLTU};
	assign b_in = op_b ^ {`EXEC_XLEN{sub}}; // a + ~b + 1 for subtraction

	assign {carry, sum} = {1'b0, op_a} + {1'b0, b_in} + {{`EXEC_XLEN{1'b0}}, sub};

	assign overflow = (op_a[`EXEC_XLEN-1] == b_in[`EXEC_XLEN-1]) &&
		(sum[`EXEC_XLEN-1] != op_a[`EXEC_XLEN-1]);
	assign lt_s = sum[`EXEC_XLEN-1] ^ overflow;
	assign lt_u = ~carry; // no carry out means a borrow

	assign sh_left  = (ctrl.op == exec_pkg::OP_SLL);
	assign sh_arith = (ctrl.op == exec_pkg::OP_SRA);

	// word shifts see only the low half, extended to suit the shift kind
	always_comb begin
		if (ctrl.word) begin
			if (sh_arith) begin
				sh_in = {{WLEN{op_a[WLEN-1]}}, op_a[WLEN-1:0]};
			end else begin
				sh_in = {{WLEN{1'b0}}, op_a[WLEN-1:0]};
			end
			sh_amt = {1'b0, op_b[`EXEC_SHAMT_W_WORD-1:0]}; // bit 5 of op_b ignored
		end else begin
			sh_in  = op_a;
			sh_amt = op_b[`EXEC_SHAMT_W-1:0];
		end
	end

	barrel_shifter u_shifter (
		.din   (sh_in),
		.shamt (sh_amt),
		.left  (sh_left),
		.arith (sh_arith),
		.dout  (sh_out)
	);

	always_comb begin
		case (ctrl.op)
			exec_pkg::OP_ADD,
			exec_pkg::OP_SUB:  raw = sum;
			exec_pkg::OP_AND:  raw = op_a & op_b;
			exec_pkg::OP_OR:   raw = op_a | op_b;
			exec_pkg::OP_XOR:  raw = op_a ^ op_b;
			exec_pkg::OP_SLT:  raw = {{(`EXEC_XLEN-1){1'b0}}, lt_s};
			exec_pkg::OP_SLTU: raw = {{(`EXEC_XLEN-1){1'b0}}, lt_u};
			exec_pkg::OP_SLL,
			exec_pkg::OP_SRL,
			exec_pkg::OP_SRA:  raw = sh_out;
			default:           raw = sum;
		endcase
	end

	// word results sign-extend from bit 31
	assign result = ctrl.word ? {{WLEN{raw[WLEN-1]}}, raw[WLEN-1:0]} : raw;
	assign zero   = ~|result;

endmodule

`default_nettype wire

// ==== hdl/exec_stage.sv ====
`default_nettype none

`include "exec_defines.svh"

module exec_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               req_valid,
	input  exec_pkg::ex_req_t  req,
	output logic               resp_valid,
	output exec_pkg::ex_resp_t resp
);

	exec_pkg::alu_ctrl_t   ctrl;
	logic                  illegal;
	logic [`EXEC_XLEN-1:0] result;
	logic                  zero;
	exec_pkg::ex_resp_t    resp_d;

	alu_ctrl_decode u_decode (
		.cls     (req.cls),
		.funct3  (req.funct3),
		.funct7  (req.funct7),
		.word    (req.word),
		.ctrl    (ctrl),
		.illegal (illegal)
	);

	alu u_alu (
		.ctrl   (ctrl),
		.op_a   (req.op_a),
		.op_b   (req.op_b),
		.result (result),
		.zero   (zero)
	);

	assign resp_d = '{result: result, zero: zero, illegal: illegal};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			resp_valid <= 1'b0;
			resp       <= '0;
		end else begin
			resp_valid <= req_valid;
			if (req_valid) begin
				resp <= resp_d; // holds last response in idle cycles
			end
		end
	end

	// one-cycle latency, no drops and no extra responses
	a_resp_latency: assert property (@(posedge clk) disable iff (!rst_n)
		1'b1 |=> (resp_valid == $past(req_valid)));

	a_resp_known: assert property (@(posedge clk) disable iff (!rst_n)
		resp_valid |-> !$isunknown(resp));

	// decoder fallback must reach the alu as a plain 64-bit add
	a_illegal_add: assert property (@(posedge clk) disable iff (!rst_n)
		(req_valid && illegal) |-> (ctrl.op == exec_pkg::OP_ADD && !ctrl.word));

endmodule

`default_nettype wire

// ==== tests/exec_checker.sv ====
`default_nettype none

`include "exec_defines.svh"

module exec_checker (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               req_valid,
	input  exec_pkg::ex_req_t  req,
	input  logic               resp_valid,
	input  exec_pkg::ex_resp_t resp,
	input  logic               drain,
	output int                 mismatch_count,
	output int                 other_count,
	output int                 req_count,
	output int                 resp_count
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF = `EXEC_XLEN / 2;

	exec_pkg::ex_resp_t expect_q [$];
	exec_pkg::ex_resp_t exp_resp;
	logic               prev_valid;
	logic               drained;

	// expected response straight from the decode and alu rules
	function automatic exec_pkg::ex_resp_t expected_resp(input exec_pkg::ex_req_t r);
		exec_pkg::ex_resp_t           o;
		exec_pkg::alu_op_e            op;
		logic                         by_funct;
		logic                         word_op;
		logic [`EXEC_XLEN-1:0]        res;
		logic signed [`EXEC_XLEN-1:0] src;
		int                           sh;
		by_funct  = (r.cls == exec_pkg::CLASS_REG) || (r.cls == exec_pkg::CLASS_IMM);
		o.illegal = 1'b0;
		if (r.cls == exec_pkg::CLASS_REG && r.funct7 != 7'h00 && r.funct7 != 7'h20)
			o.illegal = 1'b1;
		if (r.cls == exec_pkg::CLASS_REG && r.funct7 == 7'h20 && !(r.funct3 inside {3'd0, 3'd5}))
			o.illegal = 1'b1;
		if (r.cls == exec_pkg::CLASS_IMM && r.funct3 inside {3'd1, 3'd5} &&
			|{r.funct7[6], r.funct7[4:1]})
			o.illegal = 1'b1; // reserved bits of a shift immediate
		if (by_funct && r.word && r.funct3 inside {3'd2, 3'd3, 3'd4, 3'd6, 3'd7})
			o.illegal = 1'b1;
		word_op = by_funct && r.word && !o.illegal;
		if (o.illegal || r.cls == exec_pkg::CLASS_MEM) begin
			op = exec_pkg::OP_ADD;
		end else if (r.cls == exec_pkg::CLASS_BRANCH) begin
			op = exec_pkg::OP_SUB;
		end else begin
			case (r.funct3)
				3'd0: op = (r.cls == exec_pkg::CLASS_REG && r.funct7 == 7'h20) ?
					exec_pkg::OP_SUB : exec_pkg::OP_ADD;
				3'd1: op = exec_pkg::OP_SLL;
				3'd2: op = exec_pkg::OP_SLT;
				3'd3: op = exec_pkg::OP_SLTU;
				3'd4: op = exec_pkg::OP_XOR;
				3'd5: op = r.funct7[5] ? exec_pkg::OP_SRA : exec_pkg::OP_SRL;
				3'd6: op = exec_pkg::OP_OR;
				default: op = exec_pkg::OP_AND;
			endcase
		end
		sh = word_op ? int'(r.op_b[4:0]) : int'(r.op_b[5:0]);
		if (!word_op)
			src = r.op_a;
		else if (op == exec_pkg::OP_SRA)
			src = {{HALF{r.op_a[HALF-1]}}, r.op_a[HALF-1:0]};
		else
			src = {{HALF{1'b0}}, r.op_a[HALF-1:0]};
		case (op)
			exec_pkg::OP_SUB:  res = r.op_a - r.op_b;
			exec_pkg::OP_AND:  res = r.op_a & r.op_b;
			exec_pkg::OP_OR:   res = r.op_a | r.op_b;
			exec_pkg::OP_XOR:  res = r.op_a ^ r.op_b;
			exec_pkg::OP_SLT:  res = ($signed(r.op_a) < $signed(r.op_b)) ? 64'd1 : 64'd0;
			exec_pkg::OP_SLTU: res = (r.op_a < r.op_b) ? 64'd1 : 64'd0;
			exec_pkg::OP_SLL:  res = src << sh;
			exec_pkg::OP_SRL:  res = src >> sh;
			exec_pkg::OP_SRA:  res = src >>> sh;
			default:           res = r.op_a + r.op_b;
		endcase
		if (word_op)
			res = {{HALF{res[HALF-1]}}, res[HALF-1:0]};
		o.result = res;
		o.zero   = (res == '0);
		return o;
	endfunction

	task automatic compare_resp(input exec_pkg::ex_resp_t exp, input exec_pkg::ex_resp_t got);
		if (got.result !== exp.result) begin
			mismatch_count++;
			$display("mismatch resp.result: got %h expected %h", got.result, exp.result);
		end
		if (got.zero !== exp.zero) begin
			mismatch_count++;
			$display("mismatch resp.zero: got %h expected %h", got.zero, exp.zero);
		end
		if (got.illegal !== exp.illegal) begin
			mismatch_count++;
			$display("mismatch resp.illegal: got %h expected %h", got.illegal, exp.illegal);
		end
	endtask

	initial begin
		mismatch_count = 0;
		other_count    = 0;
		req_count      = 0;
		resp_count     = 0;
		prev_valid     = 1'b0;
		drained        = 1'b0;
	end

	// requests and responses are both stable at the falling edge
	always @(negedge clk) begin
		if (!rst_n) begin
			if (resp_valid !== 1'b0) begin
				mismatch_count++;
				$display("mismatch resp_valid: got %h expected %h", resp_valid, 1'b0);
			end
			if (resp !== '0) begin
				mismatch_count++;
				$display("mismatch resp: got %h expected %h", resp, 66'h0);
			end
			prev_valid = 1'b0;
		end else begin
			if (resp_valid !== prev_valid) begin
				mismatch_count++;
				$display("mismatch resp_valid: got %h expected %h", resp_valid, prev_valid);
			end
			if (resp_valid === 1'b1) begin
				resp_count++;
				if (expect_q.size() == 0) begin
					other_count++;
					$display("response at %0t ns without an outstanding request", $time);
				end else begin
					exp_resp = expect_q.pop_front();
					compare_resp(exp_resp, resp);
				end
			end
			if (req_valid === 1'b1) begin
				expect_q.push_back(expected_resp(req));
				req_count++;
			end
			prev_valid = (req_valid === 1'b1);
			if (drain === 1'b1 && !drained) begin
				drained = 1'b1; // end of run checks happen once
				if (expect_q.size() != 0) begin
					other_count++;
					$display("%0d expected responses never arrived", expect_q.size());
				end
				if (req_count != resp_count) begin
					other_count++;
					$display("sent %0d requests but saw %0d responses", req_count, resp_count);
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tests/exec_tb.sv ====
`default_nettype none

module exec_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD   = 4;
	localparam int RST_CYCLES   = 10;
	localparam int MAX_DIRECTED = 200; // bound on directed and idle cycles
	localparam int N_RANDOM     = 2000;
	localparam int WATCHDOG_NS  = (RST_CYCLES + MAX_DIRECTED + N_RANDOM) * CLK_PERIOD + 200;

	logic               clk;
	logic               rst_n;
	logic               req_valid;
	exec_pkg::ex_req_t  req;
	logic               resp_valid;
	exec_pkg::ex_resp_t resp;
	logic               drain;
	int                 mismatch_count;
	int                 other_count;
	int                 req_count;
	int                 resp_count;
	integer             seed;

	// signed/unsigned boundary pairs plus one plain pair
	logic [63:0] pair_a [4] = '{64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff, 64'h0,
		64'h0123_4567_89ab_cdef};
	logic [63:0] pair_b [4] = '{64'h1, 64'h0, 64'hffff_ffff_ffff_ffff, 64'h0fed_cba9_8765_4321};
	logic [2:0]  alu_f3 [6] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
	logic [2:0]  sh_f3 [3] = '{3'd1, 3'd5, 3'd5};
	logic [6:0]  sh_f7 [3] = '{7'h00, 7'h00, 7'h20};
	logic [63:0] shift_amts [5] = '{64'd0, 64'd1, 64'd31, 64'd32, 64'd63};
	logic [63:0] shift_vals [2] = '{64'hf0f0_1234_8000_0001, 64'h0123_4567_7654_3210};

	exec_stage DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req        (req),
		.resp_valid (resp_valid),
		.resp       (resp)
	);

	exec_checker u_check (
		.clk            (clk),
		.rst_n          (rst_n),
		.req_valid      (req_valid),
		.req            (req),
		.resp_valid     (resp_valid),
		.resp           (resp),
		.drain          (drain),
		.mismatch_count (mismatch_count),
		.other_count    (other_count),
		.req_count      (req_count),
		.resp_count     (resp_count)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic send(input exec_pkg::alu_class_e cls, input logic [2:0] f3,
		input logic [6:0] f7, input logic w, input logic [63:0] a, input logic [63:0] b);
		req_valid = 1'b1;
		req       = '{cls: cls, funct3: f3, funct7: f7, word: w, op_a: a, op_b: b};
		@(posedge clk);
		#1;
	endtask

	task automatic idle(input int n);
		req_valid = 1'b0;
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic run_directed();
		logic [63:0] b;
		for (int c = 0; c < 2; c++)
			for (int f = 0; f < 6; f++)
				for (int p = 0; p < 4; p++)
					send(c ? exec_pkg::CLASS_IMM : exec_pkg::CLASS_REG, alu_f3[f], 7'h00, 1'b0,
						pair_a[p], pair_b[p]);
		for (int p = 0; p < 4; p++)
			send(exec_pkg::CLASS_REG, 3'd0, 7'h20, 1'b0, pair_a[p], pair_b[p]); // sub
		idle(3);
		for (int w = 0; w < 2; w++)
			for (int s = 0; s < 3; s++)
				for (int k = 0; k < 5; k++)
					for (int v = 0; v < 2; v++) begin
						b = shift_amts[k] | ((k % 2) ? 64'hdead_beef_0000_0f00 : 64'h0);
						send(exec_pkg::CLASS_REG, sh_f3[s], sh_f7[s], w[0], shift_vals[v], b);
					end
		send(exec_pkg::CLASS_IMM, 3'd5, 7'h21, 1'b0, shift_vals[0], 64'd63); // srai with shamt[5] in f7
		idle(2);
		send(exec_pkg::CLASS_REG, 3'd0, 7'h00, 1'b1, 64'h7fff_ffff, 64'h1); // addw into bit 31
		send(exec_pkg::CLASS_REG, 3'd0, 7'h20, 1'b1, 64'h0, 64'h1);
		send(exec_pkg::CLASS_IMM, 3'd0, 7'h00, 1'b1, 64'hffff_ffff_0000_0005,
			64'hffff_ffff_ffff_fffb);
		send(exec_pkg::CLASS_MEM, 3'd5, 7'h7f, 1'b1, 64'h1000, 64'hffff_ffff_ffff_fff8);
		send(exec_pkg::CLASS_BRANCH, 3'd7, 7'h20, 1'b1, 64'h55aa, 64'h55aa); // equal operands set zero
		send(exec_pkg::CLASS_BRANCH, 3'd1, 7'h01, 1'b0, 64'h3, 64'h5);
		idle(1);
		send(exec_pkg::CLASS_REG, 3'd1, 7'h01, 1'b0, 64'h10, 64'h20);
		send(exec_pkg::CLASS_REG, 3'd4, 7'h20, 1'b0, 64'h11, 64'h33);
		send(exec_pkg::CLASS_IMM, 3'd1, 7'h40, 1'b0, 64'h12, 64'h3);
		send(exec_pkg::CLASS_IMM, 3'd5, 7'h22, 1'b0, 64'h13, 64'h4);
		send(exec_pkg::CLASS_REG, 3'd2, 7'h00, 1'b1, 64'h14, 64'h5);
		send(exec_pkg::CLASS_IMM, 3'd6, 7'h00, 1'b1, 64'h15, 64'h6);
		idle(2);
	endtask

	task automatic run_random();
		logic [31:0] rnd;
		for (int i = 0; i < N_RANDOM; i++) begin
			rnd        = $random(seed);
			req.cls    = exec_pkg::alu_class_e'(rnd[3:2]);
			req.funct3 = rnd[6:4];
			req.word   = rnd[7];
			case (rnd[9:8])
				2'd0: req.funct7 = 7'h00;
				2'd1: req.funct7 = 7'h20;
				2'd2: req.funct7 = 7'h01;
				default: req.funct7 = rnd[16:10];
			endcase
			req.op_a  = {$random(seed), $random(seed)};
			req.op_b  = rnd[22] ? {$random(seed), $random(seed)} : {58'h0, rnd[29:24]};
			req_valid = (rnd[21:20] != 2'b00); // about a quarter idle
			@(posedge clk);
			#1;
		end
	endtask

	initial begin
		seed      = 32'he911;
		rst_n     = 1'b0;
		req_valid = 1'b0;
		req       = '0;
		drain     = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		idle(2);
		run_directed();
		run_random();
		idle(4);
		drain = 1'b1;
		@(posedge clk);
		#1;
		$display("errors: %0d mismatches, %0d other; %0d requests, %0d responses",
			mismatch_count, other_count, req_count, resp_count);
		if (mismatch_count == 0 && other_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hdl
hdl/exec_pkg.sv
hdl/alu_ctrl_decode.sv
hdl/barrel_shifter.sv
hdl/alu.sv
hdl/exec_stage.sv
tests/exec_checker.sv
tests/exec_tb.sv

// ==== Bender.yml ====
package:
  name: exec_stage

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/exec_pkg.sv
      - hdl/alu_ctrl_decode.sv
      - hdl/barrel_shifter.sv
      - hdl/alu.sv
      - hdl/exec_stage.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/exec_checker.sv
      - tests/exec_tb.sv
